/* apb_protocol_monitor.f */
+incdir+hdl
hdl/apb_mon_pkg.sv
hdl/apb_phase_ctrl.sv
hdl/apb_stability_check.sv
hdl/apb_strobe_check.sv
hdl/apb_watchdog.sv
hdl/apb_violation_log.sv
hdl/apb_protocol_monitor.sv
verification/apb_monitor_assertions.sv
verification/tb_apb_protocol_monitor.sv

/* hdl/apb_mon_consts.svh */
`ifndef APB_MON_CONSTS_SVH
`define APB_MON_CONSTS_SVH

////////////////////////////////////////////////////////////
// Observed APB4 bus geometry
////////////////////////////////////////////////////////////

`define APB_ADDR_W     32
`define APB_DATA_W     32
// One strobe per data byte
`define APB_STRB_W     4
// Address bits that select a byte inside a data word
`define APB_ADDR_LSB   2

////////////////////////////////////////////////////////////
// Monitor limits
////////////////////////////////////////////////////////////

// Wait cycles tolerated before the watchdog fires
`define APB_WDOG_LIMIT 16
`define APB_COUNT_W    8

`endif

/* hdl/apb_mon_pkg.sv */
`include "apb_mon_consts.svh"

package apb_mon_pkg;

  // One sample of the APB4 bus, taken at each PCLK edge
  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [2:0]             pprot;
    logic [`APB_STRB_W-1:0] pstrb;
    logic [`APB_DATA_W-1:0] pwdata;
    logic                   pready;
  } apb_bus_t;

  // Request fields that hold for the whole transfer
  typedef struct packed {
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [2:0]             pprot;
  } apb_req_t;

  // Write fields that hold for the whole write transfer
  typedef struct packed {
    logic [`APB_STRB_W-1:0] pstrb;
    logic [`APB_DATA_W-1:0] pwdata;
  } apb_wpay_t;

  // One flag per protocol rule
  typedef struct packed {
    logic psel_drop;
    logic penable_in_setup;
    logic penable_low_in_access;
    logic req_unstable;
    logic wpay_unstable;
    logic addr_unaligned;
    logic strb_shape;
    logic strb_misaligned;
    logic strb_on_read;
    logic watchdog;
  } apb_viol_t;

endpackage

/* hdl/apb_phase_ctrl.sv */
`timescale 1ns/10ps

module apb_phase_ctrl
(
  input  logic                  PCLK,
  input  logic                  PRESETn,
  input  apb_mon_pkg::apb_bus_t apb,
  output logic                  setup_phase,
  output logic                  access_phase,
  output logic                  wait_state,
  output logic                  psel_drop,
  output logic                  penable_in_setup,
  output logic                  penable_low_in_access
);

  // PSEL seen at the previous edge
  logic prev_psel;
  // Previous cycle was an access cycle with PREADY high
  logic prev_done;
  // Previous cycle was a setup or a wait cycle
  logic access_q;

  ////////////////////////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////////////////////////

  // Setup on a fresh PSEL or on a back-to-back transfer
  assign setup_phase  = apb.psel & (~prev_psel | prev_done);

  // Access follows setup and lasts until PREADY while still selected
  assign access_phase = access_q & apb.psel;
  assign wait_state   = access_phase & ~apb.pready;

  ////////////////////////////////////////////////////////////
  // Control rules
  ////////////////////////////////////////////////////////////

  // Transfer still open from last cycle, so PSEL may not go low
  assign psel_drop = access_q & ~apb.psel;

  // PENABLE low in setup, high in every access cycle
  assign penable_in_setup      = setup_phase & apb.penable;
  assign penable_low_in_access = access_phase & ~apb.penable;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_psel <= 1'b0;
      prev_done <= 1'b0;
      access_q  <= 1'b0;
    end
    else
    begin
      prev_psel <= apb.psel;
      prev_done <= access_phase & apb.pready;
      // A setup or a wait cycle keeps the transfer open
      access_q  <= setup_phase | wait_state;
    end
  end

endmodule

/* hdl/apb_protocol_monitor.sv */
`timescale 1ns/10ps

`include "apb_mon_consts.svh"

module apb_protocol_monitor
(
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  apb_mon_pkg::apb_bus_t   apb,
  input  logic                    viol_clear,
  output apb_mon_pkg::apb_viol_t  viol_sticky,
  output logic [`APB_COUNT_W-1:0] viol_count
);

  import apb_mon_pkg::*;

  // Phases from the control module
  logic      setup_phase;
  logic      access_phase;
  logic      wait_state;

  // Payloads held across a transfer
  apb_req_t  req;
  apb_wpay_t wpay;
  // Write payload is only tracked on writes
  logic      wr_gate;

  // Per-rule flags for this cycle
  logic      psel_drop;
  logic      penable_in_setup;
  logic      penable_low_in_access;
  logic      req_unstable;
  logic      wpay_unstable;
  logic      addr_unaligned;
  logic      strb_shape;
  logic      strb_misaligned;
  logic      strb_on_read;
  logic      wdog_expired;
  apb_viol_t viol_event;

  assign req     = '{paddr: apb.paddr, pwrite: apb.pwrite, pprot: apb.pprot};
  assign wpay    = '{pstrb: apb.pstrb, pwdata: apb.pwdata};
  assign wr_gate = apb.pwrite;

  ////////////////////////////////////////////////////////////
  // Control and checkers
  ////////////////////////////////////////////////////////////

  apb_phase_ctrl u_phase_ctrl
  (
    .PCLK                  (PCLK),
    .PRESETn               (PRESETn),
    .apb                   (apb),
    .setup_phase           (setup_phase),
    .access_phase          (access_phase),
    .wait_state            (wait_state),
    .psel_drop             (psel_drop),
    .penable_in_setup      (penable_in_setup),
    .penable_low_in_access (penable_low_in_access)
  );

  apb_stability_check #(.payload_t(apb_req_t)) u_req_stable
  (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .capture  (setup_phase),
    .compare  (access_phase),
    .payload  (req),
    .unstable (req_unstable)
  );

  apb_stability_check #(.payload_t(apb_wpay_t)) u_wpay_stable
  (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .capture  (setup_phase & wr_gate),
    .compare  (access_phase & wr_gate),
    .payload  (wpay),
    .unstable (wpay_unstable)
  );

  apb_strobe_check u_strobe_check
  (
    .apb             (apb),
    .addr_unaligned  (addr_unaligned),
    .strb_shape      (strb_shape),
    .strb_misaligned (strb_misaligned),
    .strb_on_read    (strb_on_read)
  );

  apb_watchdog #(.LIMIT(`APB_WDOG_LIMIT)) u_watchdog
  (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .wait_state (wait_state),
    .expired    (wdog_expired)
  );

  ////////////////////////////////////////////////////////////
  // Event vector into the log
  ////////////////////////////////////////////////////////////

  assign viol_event = '{
    psel_drop:             psel_drop,
    penable_in_setup:      penable_in_setup,
    penable_low_in_access: penable_low_in_access,
    req_unstable:          req_unstable,
    wpay_unstable:         wpay_unstable,
    addr_unaligned:        addr_unaligned,
    strb_shape:            strb_shape,
    strb_misaligned:       strb_misaligned,
    strb_on_read:          strb_on_read,
    watchdog:              wdog_expired
  };

  apb_violation_log u_violation_log
  (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .clear    (viol_clear),
    .event_in (viol_event),
    .sticky   (viol_sticky),
    .count    (viol_count)
  );

endmodule

/* hdl/apb_stability_check.sv */
`timescale 1ns/10ps

module apb_stability_check
#(
  parameter type payload_t = logic
)
(
  input  logic     PCLK,
  input  logic     PRESETn,
  input  logic     capture,
  input  logic     compare,
  input  payload_t payload,
  output logic     unstable
);

  // Payload value seen in the setup cycle
  payload_t held;
  // Set once a value has been captured since reset
  logic     held_valid;

  // Snapshot of the payload at setup
  always_ff @(posedge PCLK)
  begin
    if (capture)
      held <= payload;
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      held_valid <= 1'b0;
    else if (capture)
      held_valid <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Any difference from the snapshot during access is a change
  ////////////////////////////////////////////////////////////

  assign unstable = compare & held_valid & (payload != held);

endmodule

/* hdl/apb_strobe_check.sv */
`timescale 1ns/10ps

`include "apb_mon_consts.svh"

module apb_strobe_check
(
  input  apb_mon_pkg::apb_bus_t apb,
  output logic                  addr_unaligned,
  output logic                  strb_shape,
  output logic                  strb_misaligned,
  output logic                  strb_on_read
);

  // Byte offset of PADDR inside the data word
  logic [`APB_ADDR_LSB-1:0] addr_lo;
  // Strobe is a byte, halfword or word pattern
  logic                     shape_ok;
  // Lowest enabled byte lane of a valid pattern
  logic [`APB_ADDR_LSB-1:0] first_lane;
  logic                     strb_any;

  assign addr_lo  = apb.paddr[`APB_ADDR_LSB-1:0];
  assign strb_any = |apb.pstrb;

  ////////////////////////////////////////////////////////////
  // Strobe pattern decode for a four-lane bus
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    shape_ok   = 1'b1;
    first_lane = '0;
    case (apb.pstrb)
      // Single bytes
      4'b0001: first_lane = 2'd0;
      4'b0010: first_lane = 2'd1;
      4'b0100: first_lane = 2'd2;
      4'b1000: first_lane = 2'd3;
      // Halfwords on even lanes
      4'b0011: first_lane = 2'd0;
      4'b1100: first_lane = 2'd2;
      // Full word
      4'b1111: first_lane = 2'd0;
      default: shape_ok   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Rules, checked only while selected
  ////////////////////////////////////////////////////////////

  assign addr_unaligned = apb.psel & (|addr_lo);
  assign strb_on_read   = apb.psel & ~apb.pwrite & strb_any;
  assign strb_shape     = apb.psel & apb.pwrite & strb_any & ~shape_ok;

  // A word address may pick any lane
  // a byte address has to point at the first strobed lane
  assign strb_misaligned = apb.psel & apb.pwrite & shape_ok &
                           (|addr_lo) & (addr_lo != first_lane);

endmodule

/* hdl/apb_violation_log.sv */
`timescale 1ns/10ps

`include "apb_mon_consts.svh"

module apb_violation_log
(
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    clear,
  input  apb_mon_pkg::apb_viol_t  event_in,
  output apb_mon_pkg::apb_viol_t  sticky,
  output logic [`APB_COUNT_W-1:0] count
);

  import apb_mon_pkg::*;

  // At least one rule broken in this cycle
  logic any_event;
  logic count_max;

  assign any_event = |event_in;
  assign count_max = &count;

  ////////////////////////////////////////////////////////////
  // Sticky flags and violation-cycle counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      sticky <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      // Same-cycle events are dropped with the clear
      sticky <= '0;
      count  <= '0;
    end
    else
    begin
      sticky <= apb_viol_t'(sticky | event_in);
      if (any_event && !count_max)
        count <= count + 1'b1;
    end
  end

endmodule

/* hdl/apb_watchdog.sv */
`timescale 1ns/10ps

module apb_watchdog
#(
  parameter int LIMIT = 16
)
(
  input  logic PCLK,
  input  logic PRESETn,
  input  logic wait_state,
  output logic expired
);

  localparam int CNT_W = $clog2(LIMIT + 1);

  // Consecutive wait cycles seen so far, held at LIMIT
  logic [CNT_W-1:0] wait_cnt;
  logic             at_limit;

  assign at_limit = (wait_cnt == CNT_W'(LIMIT));

  // Fires in every wait cycle past the limit
  assign expired = wait_state & at_limit;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      wait_cnt <= '0;
    else if (!wait_state)
      // Any completed or idle cycle restarts the count
      wait_cnt <= '0;
    else if (!at_limit)
      wait_cnt <= wait_cnt + 1'b1;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the APB monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_apb_protocol_monitor
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -f apb_protocol_monitor.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** TEST FAILED ***' "$LOG"; then
  exit 1
fi
if ! grep -q -F '*** TEST PASSED ***' "$LOG"; then
  echo "Simulation log has no pass line"
  exit 1
fi
exit 0

/* verification/apb_monitor_assertions.sv */
`timescale 1ns/10ps

`include "apb_mon_consts.svh"

module apb_monitor_assertions
(
  input logic                    PCLK,
  input logic                    PRESETn,
  input logic                    clear,
  input apb_mon_pkg::apb_viol_t  sticky,
  input logic [`APB_COUNT_W-1:0] count
);

  // Log is empty on the first edge out of reset
  log_empty_after_reset: assert property (@(posedge PCLK)
    $rose(PRESETn) |-> (sticky == '0) && (count == '0))
    else $error("Violation log not empty after reset");

  // Sticky flags only fall through clear
  sticky_never_falls: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !$past(clear) |-> ((sticky & $past(sticky)) == $past(sticky)))
    else $error("Sticky flag fell without clear");

  // Counter only moves up or saturates
  count_never_drops: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !$past(clear) |-> (count >= $past(count)))
    else $error("Violation count decreased without clear");

endmodule

bind apb_violation_log apb_monitor_assertions u_log_assertions
(
  .PCLK    (PCLK),
  .PRESETn (PRESETn),
  .clear   (clear),
  .sticky  (sticky),
  .count   (count)
);

/* verification/tb_apb_protocol_monitor.sv */
`timescale 1ns/10ps

`include "apb_mon_consts.svh"

module tb_apb_protocol_monitor;

  import apb_mon_pkg::*;

  // Longest test is about 150 cycles, so this leaves a wide margin
  localparam int CYCLE_LIMIT = 2000;

  logic                    PCLK;
  logic                    PRESETn;
  apb_bus_t                bus;
  logic                    viol_clear;
  apb_viol_t               viol_sticky;
  logic [`APB_COUNT_W-1:0] viol_count;

  logic [31:0] lfsr = 32'hebcf_756e;
  int          cycle_cnt = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;

  apb_protocol_monitor u_apb_protocol_monitor
  (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .apb         (bus),
    .viol_clear  (viol_clear),
    .viol_sticky (viol_sticky),
    .viol_count  (viol_count)
  );

  initial PCLK = 1'b0;
  always #5 PCLK = ~PCLK;

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    int          k;
    val = '0;
    for (k = 0; k < n; k++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return val;
  endfunction

  // Byte lanes, even halfwords, full word
  function automatic logic [3:0] valid_strobe(input logic [2:0] sel);
    case (sel)
      3'd0: return 4'b0001;
      3'd1: return 4'b0010;
      3'd2: return 4'b0100;
      3'd3: return 4'b1000;
      3'd4: return 4'b0011;
      3'd5: return 4'b1100;
      default: return 4'b1111;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus cycles, each driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic setup_cycle(input logic wr, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [31:0] data);
    @(negedge PCLK);
    bus.psel    = 1'b1;
    bus.penable = 1'b0;
    bus.pwrite  = wr;
    bus.paddr   = addr;
    bus.pprot   = 3'(rand_bits(3));
    bus.pstrb   = strb;
    bus.pwdata  = data;
    bus.pready  = 1'b0;
  endtask

  task automatic access_cycle(input logic ready);
    @(negedge PCLK);
    bus.penable = 1'b1;
    bus.pready  = ready;
  endtask

  task automatic idle_cycle();
    @(negedge PCLK);
    bus = '0;
  endtask

  // Setup, then access with the given number of wait states
  task automatic run_transfer(input logic wr, input logic [31:0] addr,
                              input logic [3:0] strb, input logic [31:0] data,
                              input int waits);
    int i;
    setup_cycle(wr, addr, strb, data);
    access_cycle(waits == 0);
    for (i = 0; i < waits; i++)
      access_cycle(i == waits - 1);
    idle_cycle();
  endtask

  task automatic clear_log();
    @(negedge PCLK);
    viol_clear = 1'b1;
    @(negedge PCLK);
    viol_clear = 1'b0;
  endtask

  // One idle edge so the last event is registered
  task automatic check_log(input string name, input apb_viol_t exp_sticky,
                           input int exp_count);
    @(negedge PCLK);
    check_cnt++;
    if (viol_sticky !== exp_sticky)
    begin
      err_cnt++;
      $display("ERR viol_sticky (%s): expected 0x%03h, got 0x%03h",
               name, exp_sticky, viol_sticky);
    end
    if (viol_count !== `APB_COUNT_W'(exp_count))
    begin
      err_cnt++;
      $display("ERR viol_count (%s): expected 0x%02h, got 0x%02h",
               name, `APB_COUNT_W'(exp_count), viol_count);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic clean_random_traffic();
    logic [31:0] pick;
    logic        wr;
    logic [3:0]  strb;
    int          n;
    for (n = 0; n < 12; n++)
    begin
      pick = rand_bits(1);
      wr   = pick[0];
      pick = rand_bits(3);
      // Word-aligned address accepts any valid shape
      strb = wr ? valid_strobe(pick[2:0]) : 4'h0;
      pick = rand_bits(2);
      run_transfer(wr, rand_bits(30) << 2, strb, rand_bits(32), int'(pick[1:0]));
    end
    check_log("clean traffic", '0, 0);
  endtask

  task automatic penable_errors();
    apb_viol_t   exp;
    logic [31:0] addr;
    exp  = '0;
    addr = rand_bits(30) << 2;
    clear_log();
    // PENABLE one cycle early
    setup_cycle(1'b0, addr, 4'h0, 32'h0);
    bus.penable = 1'b1;
    access_cycle(1'b1);
    idle_cycle();
    exp.penable_in_setup = 1'b1;
    check_log("penable in setup", exp, 1);
    // PENABLE low in the first of two access cycles
    setup_cycle(1'b0, addr, 4'h0, 32'h0);
    access_cycle(1'b0);
    bus.penable = 1'b0;
    access_cycle(1'b1);
    idle_cycle();
    exp.penable_low_in_access = 1'b1;
    check_log("penable low in access", exp, 2);
    clear_log();
    check_log("after clear", '0, 0);
  endtask

  task automatic payload_changes();
    apb_viol_t   exp;
    logic [31:0] addr;
    logic [31:0] data;
    addr = rand_bits(30) << 2;
    data = rand_bits(32);
    clear_log();
    // PADDR moves in the second wait cycle, then returns
    setup_cycle(1'b0, addr, 4'h0, data);
    access_cycle(1'b0);
    access_cycle(1'b0);
    bus.paddr = addr ^ 32'h0000_0010;
    access_cycle(1'b1);
    bus.paddr = addr;
    idle_cycle();
    exp = '0;
    exp.req_unstable = 1'b1;
    check_log("paddr change", exp, 1);
    clear_log();
    // PWDATA moves in a write wait cycle
    setup_cycle(1'b1, addr, 4'hf, data);
    access_cycle(1'b0);
    bus.pwdata = ~data;
    access_cycle(1'b1);
    bus.pwdata = data;
    idle_cycle();
    exp = '0;
    exp.wpay_unstable = 1'b1;
    check_log("pwdata change on write", exp, 1);
    clear_log();
    // Write data is ignored on reads
    setup_cycle(1'b0, addr, 4'h0, data);
    access_cycle(1'b0);
    bus.pwdata = ~data;
    access_cycle(1'b1);
    idle_cycle();
    check_log("pwdata change on read", '0, 0);
  endtask

  // Every selected cycle breaks the rule, setup plus one access
  task automatic strobe_rules();
    apb_viol_t   exp;
    logic [31:0] addr;
    addr = rand_bits(30) << 2;
    clear_log();
    run_transfer(1'b1, addr, 4'b0101, rand_bits(32), 0);
    exp = '0;
    exp.strb_shape = 1'b1;
    check_log("split strobe", exp, 2);
    clear_log();
    run_transfer(1'b1, addr | 32'h1, 4'b0001, rand_bits(32), 0);
    exp = '0;
    exp.addr_unaligned  = 1'b1;
    exp.strb_misaligned = 1'b1;
    check_log("byte strobe off its lane", exp, 2);
    clear_log();
    run_transfer(1'b0, addr, 4'b0011, 32'h0, 0);
    exp = '0;
    exp.strb_on_read = 1'b1;
    check_log("strobe on read", exp, 2);
  endtask

  task automatic psel_drop_in_wait();
    apb_viol_t exp;
    clear_log();
    setup_cycle(1'b0, rand_bits(30) << 2, 4'h0, 32'h0);
    access_cycle(1'b0);
    idle_cycle();
    exp = '0;
    exp.psel_drop = 1'b1;
    check_log("psel drop", exp, 1);
  endtask

  // Fires from the 17th consecutive wait cycle on
  task automatic watchdog_limit();
    apb_viol_t   exp;
    logic [31:0] addr;
    addr = rand_bits(30) << 2;
    clear_log();
    run_transfer(1'b0, addr, 4'h0, 32'h0, `APB_WDOG_LIMIT);
    check_log("waits at limit", '0, 0);
    run_transfer(1'b0, addr, 4'h0, 32'h0, `APB_WDOG_LIMIT + 2);
    exp = '0;
    exp.watchdog = 1'b1;
    check_log("waits past limit", exp, 2);
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  always @(posedge PCLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    bus        = '0;
    viol_clear = 1'b0;
    PRESETn    = 1'b0;
    repeat (3) @(negedge PCLK);
    PRESETn = 1'b1;
    clean_random_traffic();
    penable_errors();
    payload_changes();
    strobe_rules();
    psel_drop_in_wait();
    watchdog_limit();
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
